// ==== src/du_consts.svh ====
`ifndef DU_CONSTS_SVH
`define DU_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////////////////////

// Data word
`define DU_XLEN 32
// Debug port address, bank code on top of the in-bank offset
`define DU_PLEN 16
`define DU_ADDR_SIZE 12

////////////////////////////////////////////////////////////////////////////
// Breakpoints
////////////////////////////////////////////////////////////////////////////

// Register slots in the map
`define DU_MAX_BREAKPOINTS 8
// Slots backed by real compare logic
`define DU_BREAKPOINTS 3

////////////////////////////////////////////////////////////////////////////
// Register map
////////////////////////////////////////////////////////////////////////////

// Bank code of the debug unit itself
`define DU_BANK_INTERNAL 4'h0

`define DU_REG_CTRL 12'h000
`define DU_REG_HIT 12'h001
`define DU_REG_IE 12'h002
`define DU_REG_CAUSE 12'h003

// Pair n sits at base + 2*n
`define DU_REG_BPCTRL0 12'h010
`define DU_REG_BPDATA0 12'h011

// Match conditions in BPCTRL bits 6..4
`define DU_CC_FETCH 3'd0
`define DU_CC_LD_ADR 3'd1
`define DU_CC_ST_ADR 3'd2
`define DU_CC_LDST_ADR 3'd3

// Major opcodes, instr[6:2]
`define DU_OPC_LOAD 5'h00
`define DU_OPC_STORE 5'h08
`define DU_OPC_BRANCH 5'h18

`endif

// ==== src/du_pkg.sv ====
`include "du_consts.svh"

package du_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////////////////////////////

  // Register and bus data word
  typedef logic [`DU_XLEN-1:0] xlen_t;

  // Full debug port address
  typedef logic [`DU_PLEN-1:0] dbg_addr_t;

  // Register offset within one bank
  typedef logic [`DU_ADDR_SIZE-1:0] du_offs_t;

  // Raw instruction word from the pipeline
  typedef logic [31:0] instr_t;

  //////////////////////////////////////////////////////////////////////////
  // Breakpoints and exceptions
  //////////////////////////////////////////////////////////////////////////

  // One flag per breakpoint register slot
  typedef logic [`DU_MAX_BREAKPOINTS-1:0] bp_vec_t;

  // Match condition code
  typedef logic [2:0] bp_cc_t;

  // Traps in 15..0, interrupts in 31..16
  typedef logic [31:0] exc_vec_t;

  // Interrupt enables handed to the core
  typedef logic [31:0] ie_t;

endpackage

// ==== src/du_access.sv ====
`timescale 1ns/1ps
`include "du_consts.svh"

module du_access (
  input  logic              clk,
  input  logic              rstn,
  input  logic              dbg_strb,
  input  logic              dbg_we,
  input  du_pkg::dbg_addr_t dbg_addr,
  input  du_pkg::xlen_t     dbg_dati,
  output logic              dbg_ack,
  output logic              we_int,
  output logic              rd_int,
  output du_pkg::du_offs_t  offs,
  output du_pkg::xlen_t     wdata
);
  import du_pkg::*;

  localparam int BANK_W = `DU_PLEN - `DU_ADDR_SIZE;

  logic              strb_dly;
  logic              strb_rise;
  logic [BANK_W-1:0] bank;
  logic              sel_int;
  du_offs_t          addr_offs;
  logic [2:0]        ack_sr;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  // Upper bits pick the bank
  assign bank      = dbg_addr[`DU_PLEN-1:`DU_ADDR_SIZE];
  assign addr_offs = dbg_addr[`DU_ADDR_SIZE-1:0];
  assign sel_int   = (bank == `DU_BANK_INTERNAL);

  // First cycle of a strobe
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      strb_dly <= 1'b0;
    end else begin
      strb_dly <= dbg_strb;
    end
  end

  assign strb_rise = dbg_strb & ~strb_dly;

  ////////////////////////////////////////////////////////////////////////////
  // Acknowledge
  ////////////////////////////////////////////////////////////////////////////

  // Ones shift in from the top while strobe is up
  // Lowest bit is the ack, clears the whole shifter next cycle
  // Other banks complete the same way
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ack_sr <= '0;
    end else begin
      ack_sr <= {3{dbg_strb & ~dbg_ack}} & {1'b1, ack_sr[2:1]};
    end
  end

  assign dbg_ack = ack_sr[0];

  ////////////////////////////////////////////////////////////////////////////
  // Registered request
  ////////////////////////////////////////////////////////////////////////////

  // Single write pulse per access, internal bank only
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      we_int <= 1'b0;
      rd_int <= 1'b0;
    end else begin
      we_int <= strb_rise & dbg_we & sel_int;
      rd_int <= dbg_strb & sel_int;
    end
  end

  // Offset and data held for the register stage
  always_ff @(posedge clk) begin
    if (dbg_strb) begin
      offs  <= addr_offs;
      wdata <= dbg_dati;
    end
  end

  // Ack is a single-cycle pulse
  a_ack_pulse : assert property (@(posedge clk) disable iff (!rstn) dbg_ack |=> !dbg_ack);

endmodule

// ==== src/cause_enc.sv ====
`timescale 1ns/1ps

module cause_enc (
  input  du_pkg::exc_vec_t exc,
  output du_pkg::xlen_t    cause,
  output logic             valid
);
  import du_pkg::*;

  // Lower half traps, upper half interrupts
  localparam int    NTRAP    = $bits(exc_vec_t) / 2;
  localparam xlen_t INT_FLAG = xlen_t'(1) << ($bits(xlen_t) - 1);

  always_comb begin
    cause = '0;
    // Interrupts scanned top down, lowest set bit wins
    for (int i = NTRAP - 1; i >= 0; i--) begin
      if (exc[NTRAP + i]) begin
        cause = INT_FLAG | xlen_t'(i);
      end
    end
    // Any trap overrides an interrupt
    for (int i = NTRAP - 1; i >= 0; i--) begin
      if (exc[i]) begin
        cause = xlen_t'(i);
      end
    end
  end

  assign valid = |exc;

endmodule

// ==== src/bp_match.sv ====
`timescale 1ns/1ps
`include "du_consts.svh"

module bp_match (
  input  du_pkg::bp_vec_t bp_en,
  input  du_pkg::bp_cc_t  bp_cc   [`DU_MAX_BREAKPOINTS],
  input  du_pkg::xlen_t   bp_data [`DU_MAX_BREAKPOINTS],
  input  logic            instr_break_ena,
  input  logic            branch_break_ena,
  input  du_pkg::xlen_t   if_pc,
  input  du_pkg::instr_t  if_instr,
  input  du_pkg::instr_t  mem_instr,
  input  logic            if_bubble,
  input  logic            mem_bubble,
  input  logic            mem_exception,
  input  logic            dmem_ack,
  input  logic            pipe_flush,
  input  du_pkg::xlen_t   mem_memadr,
  output du_pkg::bp_vec_t bp_hit,
  output logic            instr_hit,
  output logic            branch_hit
);
  import du_pkg::*;

  // Slots with compare logic behind them
  localparam bp_vec_t BUILT = bp_vec_t'((1 << `DU_BREAKPOINTS) - 1);

  logic [4:0] if_opc;
  logic [4:0] mem_opc;
  logic       mem_ok;
  logic       mem_read;
  logic       mem_write;

  assign if_opc  = if_instr[6:2];
  assign mem_opc = mem_instr[6:2];

  // Single step and branch break
  assign instr_hit  = instr_break_ena & ~if_bubble;
  assign branch_hit = branch_break_ena & ~if_bubble & (if_opc == `DU_OPC_BRANCH);

  // Only a real, acked access without exception counts
  assign mem_ok    = ~mem_exception & ~mem_bubble & dmem_ack;
  assign mem_read  = mem_ok & (mem_opc == `DU_OPC_LOAD);
  assign mem_write = mem_ok & (mem_opc == `DU_OPC_STORE);

  ////////////////////////////////////////////////////////////////////////////
  // Address compare per slot
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    bp_hit = '0;
    for (int n = 0; n < `DU_MAX_BREAKPOINTS; n++) begin
      if (BUILT[n] && bp_en[n]) begin
        case (bp_cc[n])
          // Fetch match dropped when the fetch is flushed
          `DU_CC_FETCH:    bp_hit[n] = (if_pc == bp_data[n]) & ~pipe_flush;
          `DU_CC_LD_ADR:   bp_hit[n] = (mem_memadr == bp_data[n]) & mem_read;
          `DU_CC_ST_ADR:   bp_hit[n] = (mem_memadr == bp_data[n]) & mem_write;
          `DU_CC_LDST_ADR: bp_hit[n] = (mem_memadr == bp_data[n]) & (mem_read | mem_write);
          default:         bp_hit[n] = 1'b0;
        endcase
      end
    end
  end

endmodule

// ==== src/du_regs.sv ====
`timescale 1ns/1ps
`include "du_consts.svh"

module du_regs (
  input  logic             clk,
  input  logic             rstn,
  input  logic             we_int,
  input  logic             rd_int,
  input  du_pkg::du_offs_t offs,
  input  du_pkg::xlen_t    wdata,
  input  du_pkg::bp_vec_t  bp_hit,
  input  logic             instr_hit,
  input  logic             branch_hit,
  input  logic             pipe_flush,
  input  du_pkg::exc_vec_t du_exceptions,
  output du_pkg::bp_vec_t  bp_en,
  output du_pkg::bp_cc_t   bp_cc   [`DU_MAX_BREAKPOINTS],
  output du_pkg::xlen_t    bp_data [`DU_MAX_BREAKPOINTS],
  output logic             instr_break_ena,
  output logic             branch_break_ena,
  output du_pkg::ie_t      du_ie,
  output du_pkg::xlen_t    dbg_dato,
  output logic             dbg_bp
);
  import du_pkg::*;

  localparam bp_vec_t BUILT = bp_vec_t'((1 << `DU_BREAKPOINTS) - 1);

  logic    instr_hit_q;
  logic    branch_hit_q;
  bp_vec_t bp_hit_q;
  ie_t     ie_q;
  xlen_t   cause_q;
  xlen_t   exc_cause;
  logic    exc_valid;
  xlen_t   rd_val;
  logic    wr_ctrl;
  logic    wr_hit;
  logic    wr_ie;
  logic    wr_cause;

  // Offsets of breakpoint pair n
  function automatic du_offs_t bpctrl_offs(input int n);
    return du_offs_t'(`DU_REG_BPCTRL0 + 2 * n);
  endfunction

  function automatic du_offs_t bpdata_offs(input int n);
    return du_offs_t'(`DU_REG_BPDATA0 + 2 * n);
  endfunction

  assign wr_ctrl  = we_int && (offs == `DU_REG_CTRL);
  assign wr_hit   = we_int && (offs == `DU_REG_HIT);
  assign wr_ie    = we_int && (offs == `DU_REG_IE);
  assign wr_cause = we_int && (offs == `DU_REG_CAUSE);

  ////////////////////////////////////////////////////////////////////////////
  // Control, IE, cause
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      instr_break_ena  <= 1'b0;
      branch_break_ena <= 1'b0;
      ie_q             <= '0;
    end else begin
      if (wr_ctrl) begin
        instr_break_ena  <= wdata[0];
        branch_break_ena <= wdata[1];
      end
      if (wr_ie) begin
        ie_q <= wdata[31:0];
      end
    end
  end

  assign du_ie = ie_q;

  // Priority encoded exception cause
  cause_enc cause_enc_i (
    .exc   (du_exceptions),
    .cause (exc_cause),
    .valid (exc_valid)
  );

  // Debugger write beats a capture in the same cycle
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cause_q <= '0;
    end else if (wr_cause) begin
      cause_q <= wdata;
    end else if (exc_valid) begin
      cause_q <= exc_cause;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sticky hit flags
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      instr_hit_q  <= 1'b0;
      branch_hit_q <= 1'b0;
      bp_hit_q     <= '0;
    end else if (wr_hit) begin
      instr_hit_q  <= wdata[0];
      branch_hit_q <= wdata[1];
      // No flag for a slot that does not exist
      bp_hit_q     <= wdata[4 +: `DU_MAX_BREAKPOINTS] & BUILT;
    end else begin
      instr_hit_q  <= instr_hit_q | instr_hit;
      branch_hit_q <= branch_hit_q | branch_hit;
      bp_hit_q     <= bp_hit_q | bp_hit;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Breakpoint control and data pairs
  ////////////////////////////////////////////////////////////////////////////

  // Unbuilt slots never load, so they stay at zero
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bp_en <= '0;
      for (int n = 0; n < `DU_MAX_BREAKPOINTS; n++) begin
        bp_cc[n]   <= '0;
        bp_data[n] <= '0;
      end
    end else begin
      for (int n = 0; n < `DU_MAX_BREAKPOINTS; n++) begin
        if (BUILT[n] && we_int && (offs == bpctrl_offs(n))) begin
          bp_en[n] <= wdata[1];
          bp_cc[n] <= wdata[6:4];
        end
        if (BUILT[n] && we_int && (offs == bpdata_offs(n))) begin
          bp_data[n] <= wdata;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read-back
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_val = '0;
    case (offs)
      `DU_REG_CTRL:  rd_val = xlen_t'({branch_break_ena, instr_break_ena});
      `DU_REG_HIT:   rd_val = xlen_t'({bp_hit_q, 2'b00, branch_hit_q, instr_hit_q});
      `DU_REG_IE:    rd_val = xlen_t'(ie_q);
      `DU_REG_CAUSE: rd_val = cause_q;
      default:       rd_val = '0;
    endcase
    // Implemented bit comes from the build mask
    for (int n = 0; n < `DU_MAX_BREAKPOINTS; n++) begin
      if (offs == bpctrl_offs(n)) begin
        rd_val = xlen_t'({bp_cc[n], 2'b00, bp_en[n], BUILT[n]});
      end
      if (offs == bpdata_offs(n)) begin
        rd_val = bp_data[n];
      end
    end
  end

  // Zero when the access targets another bank
  always_ff @(posedge clk) begin
    dbg_dato <= rd_int ? rd_val : '0;
  end

  // Break request, suppressed while the pipe flushes
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dbg_bp <= 1'b0;
    end else begin
      dbg_bp <= ~pipe_flush & (exc_valid | (|bp_hit) | instr_hit | branch_hit);
    end
  end

  // Neither the write path nor the match side may flag an unbuilt slot
  a_unbuilt_hits : assert property (@(posedge clk) disable iff (!rstn)
    (bp_hit_q & ~BUILT) == '0);

endmodule

// ==== src/du_top.sv ====
`timescale 1ns/1ps
`include "du_consts.svh"

module du_top (
  input  logic              clk,
  input  logic              rstn,
  input  logic              dbg_strb,
  input  logic              dbg_we,
  input  du_pkg::dbg_addr_t dbg_addr,
  input  du_pkg::xlen_t     dbg_dati,
  output du_pkg::xlen_t     dbg_dato,
  output logic              dbg_ack,
  output logic              dbg_bp,
  output du_pkg::ie_t       du_ie,
  input  du_pkg::xlen_t     if_pc,
  input  du_pkg::instr_t    if_instr,
  input  du_pkg::instr_t    mem_instr,
  input  logic              if_bubble,
  input  logic              mem_bubble,
  input  logic              mem_exception,
  input  du_pkg::xlen_t     mem_memadr,
  input  logic              dmem_ack,
  input  logic              pipe_flush,
  input  du_pkg::exc_vec_t  du_exceptions
);
  import du_pkg::*;

  // Access stage to register stage
  logic     we_int;
  logic     rd_int;
  du_offs_t offs;
  xlen_t    wdata;

  // Breakpoint setup and hits
  bp_vec_t  bp_en;
  bp_cc_t   bp_cc   [`DU_MAX_BREAKPOINTS];
  xlen_t    bp_data [`DU_MAX_BREAKPOINTS];
  logic     instr_break_ena;
  logic     branch_break_ena;
  bp_vec_t  bp_hit;
  logic     instr_hit;
  logic     branch_hit;

  du_access du_access_i (
    .clk      (clk),
    .rstn     (rstn),
    .dbg_strb (dbg_strb),
    .dbg_we   (dbg_we),
    .dbg_addr (dbg_addr),
    .dbg_dati (dbg_dati),
    .dbg_ack  (dbg_ack),
    .we_int   (we_int),
    .rd_int   (rd_int),
    .offs     (offs),
    .wdata    (wdata)
  );

  bp_match bp_match_i (
    .bp_en            (bp_en),
    .bp_cc            (bp_cc),
    .bp_data          (bp_data),
    .instr_break_ena  (instr_break_ena),
    .branch_break_ena (branch_break_ena),
    .if_pc            (if_pc),
    .if_instr         (if_instr),
    .mem_instr        (mem_instr),
    .if_bubble        (if_bubble),
    .mem_bubble       (mem_bubble),
    .mem_exception    (mem_exception),
    .dmem_ack         (dmem_ack),
    .pipe_flush       (pipe_flush),
    .mem_memadr       (mem_memadr),
    .bp_hit           (bp_hit),
    .instr_hit        (instr_hit),
    .branch_hit       (branch_hit)
  );

  du_regs du_regs_i (
    .clk              (clk),
    .rstn             (rstn),
    .we_int           (we_int),
    .rd_int           (rd_int),
    .offs             (offs),
    .wdata            (wdata),
    .bp_hit           (bp_hit),
    .instr_hit        (instr_hit),
    .branch_hit       (branch_hit),
    .pipe_flush       (pipe_flush),
    .du_exceptions    (du_exceptions),
    .bp_en            (bp_en),
    .bp_cc            (bp_cc),
    .bp_data          (bp_data),
    .instr_break_ena  (instr_break_ena),
    .branch_break_ena (branch_break_ena),
    .du_ie            (du_ie),
    .dbg_dato         (dbg_dato),
    .dbg_bp           (dbg_bp)
  );

endmodule

// ==== verif/du_tb_vectors.svh ====
`ifndef DU_TB_VECTORS_SVH
`define DU_TB_VECTORS_SVH

// Register rows: name, write?, write addr, write data, random?, expect mask, read addr, expected
// Stimulus rows: name, write?, write addr, write data, clear hits?, if_pc, if_instr,
//   if_bubble, mem_instr, mem_memadr, dmem_ack, mem_exception, pipe_flush, exceptions,
//   read addr, expected, expected dbg_bp
task automatic fill_table();
  // Reset state
  add_reg("reset_ctrl", 0, 0, 0, 0, 0, `DU_REG_CTRL, 0);
  add_reg("reset_hit", 0, 0, 0, 0, 0, `DU_REG_HIT, 0);
  add_reg("reset_ie", 0, 0, 0, 0, 0, `DU_REG_IE, 0);
  add_reg("reset_cause", 0, 0, 0, 0, 0, `DU_REG_CAUSE, 0);
  // Register access with random data
  add_reg("ie_rand", 1, `DU_REG_IE, 0, 1, 32'hffff_ffff, `DU_REG_IE, 0);
  add_reg("ctrl_rand", 1, `DU_REG_CTRL, 0, 1, 32'h0000_0003, `DU_REG_CTRL, 0);
  add_reg("ctrl_clear", 1, `DU_REG_CTRL, 0, 0, 0, `DU_REG_CTRL, 0);
  add_reg("bpdata0_rand", 1, 16'h011, 0, 1, 32'hffff_ffff, 16'h011, 0);
  add_reg("bpdata1_rand", 1, 16'h013, 0, 1, 32'hffff_ffff, 16'h013, 0);
  add_reg("bpdata2_rand", 1, 16'h015, 0, 1, 32'hffff_ffff, 16'h015, 0);
  add_reg("bpctrl1_impl", 0, 0, 0, 0, 0, 16'h012, 32'h1);
  add_reg("bpctrl3_none", 0, 0, 0, 0, 0, 16'h016, 0);
  add_reg("bpctrl7_none", 0, 0, 0, 0, 0, 16'h01e, 0);
  add_reg("bpdata3_none", 1, 16'h017, 0, 1, 0, 16'h017, 0);
  add_reg("other_bank", 1, 16'h1002, 0, 1, 0, 16'h1002, 0);
  // Fetch breakpoint on BP0
  add_reg("bp0_data", 1, 16'h011, 32'h100, 0, 0, 16'h011, 32'h100);
  add_stim("bp0_fetch", 1, 16'h010, 32'h02, 1, 32'h100, I_OP, 0, I_OP, 0, 0, 0, 0, 0,
           `DU_REG_HIT, 32'h10, 1);
  add_stim("bp0_flushed", 0, 0, 0, 1, 32'h100, I_OP, 0, I_OP, 0, 0, 0, 1, 0,
           `DU_REG_HIT, 0, 0);
  add_reg("bp0_off", 1, 16'h010, 0, 0, 0, 16'h010, 32'h1);
  // Load and store address breakpoints
  add_reg("bp1_data", 1, 16'h013, 32'h2000, 0, 0, 16'h013, 32'h2000);
  add_stim("bp1_load", 1, 16'h012, 32'h12, 1, IDLE_PC, I_OP, 1, I_LD, 32'h2000, 1, 0, 0, 0,
           `DU_REG_HIT, 32'h20, 1);
  add_stim("bp1_no_ack", 0, 0, 0, 1, IDLE_PC, I_OP, 1, I_LD, 32'h2000, 0, 0, 0, 0,
           `DU_REG_HIT, 0, 0);
  add_stim("bp1_mem_exc", 0, 0, 0, 1, IDLE_PC, I_OP, 1, I_LD, 32'h2000, 1, 1, 0, 0,
           `DU_REG_HIT, 0, 0);
  add_reg("bp2_data", 1, 16'h015, 32'h2000, 0, 0, 16'h015, 32'h2000);
  add_stim("bp2_on_load", 1, 16'h014, 32'h22, 1, IDLE_PC, I_OP, 1, I_LD, 32'h2000, 1, 0, 0, 0,
           `DU_REG_HIT, 32'h20, 1);
  add_stim("bp2_store", 0, 0, 0, 1, IDLE_PC, I_OP, 1, I_ST, 32'h2000, 1, 0, 0, 0,
           `DU_REG_HIT, 32'h40, 1);
  // Branch and single-step break
  add_stim("branch_hit", 1, `DU_REG_CTRL, 32'h2, 1, IDLE_PC, I_BR, 0, I_OP, 0, 0, 0, 0, 0,
           `DU_REG_HIT, 32'h2, 1);
  add_stim("branch_other", 0, 0, 0, 1, IDLE_PC, I_OP, 0, I_OP, 0, 0, 0, 0, 0,
           `DU_REG_HIT, 0, 0);
  add_stim("step_hit", 1, `DU_REG_CTRL, 32'h1, 1, IDLE_PC, I_OP, 0, I_OP, 0, 0, 0, 0, 0,
           `DU_REG_HIT, 32'h1, 1);
  add_reg("hit_clear", 1, `DU_REG_HIT, 0, 0, 0, `DU_REG_HIT, 0);
  add_reg("ctrl_off", 1, `DU_REG_CTRL, 0, 0, 0, `DU_REG_CTRL, 0);
  // Cause capture
  add_stim("cause_trap", 0, 0, 0, 0, IDLE_PC, I_OP, 1, I_OP, 0, 0, 0, 0, 32'h0000_0020,
           `DU_REG_CAUSE, 32'h5, 1);
  add_stim("cause_irq", 0, 0, 0, 0, IDLE_PC, I_OP, 1, I_OP, 0, 0, 0, 0, 32'h0008_0000,
           `DU_REG_CAUSE, 32'h8000_0003, 1);
  add_stim("cause_trap_wins", 0, 0, 0, 0, IDLE_PC, I_OP, 1, I_OP, 0, 0, 0, 0, 32'h0004_0200,
           `DU_REG_CAUSE, 32'h9, 1);
endtask

`endif

// ==== verif/du_tb.sv ====
`timescale 1ns/1ps
`include "du_consts.svh"

module du_tb;
  import du_pkg::*;

  localparam xlen_t  IDLE_PC = 32'hffff_fff0;
  localparam instr_t I_OP = 32'h0000_0033;
  localparam instr_t I_LD = 32'h0000_0003;
  localparam instr_t I_ST = 32'h0000_0023;
  localparam instr_t I_BR = 32'h0000_0063;

  typedef struct packed {
    logic      wr;
    dbg_addr_t waddr;
    xlen_t     wdata;
    logic      rnd;
    xlen_t     mask;
    logic      clr;
    xlen_t     pc;
    instr_t    iinstr;
    logic      ibub;
    instr_t    minstr;
    xlen_t     madr;
    logic      mack;
    logic      mexc;
    logic      flush;
    exc_vec_t  exc;
    dbg_addr_t raddr;
    xlen_t     exp;
    logic      exp_bp;
  } vec_t;

  logic      clk = 1'b0;
  logic      rstn;
  logic      dbg_strb, dbg_we, dbg_ack, dbg_bp;
  dbg_addr_t dbg_addr;
  xlen_t     dbg_dati, dbg_dato, if_pc, mem_memadr;
  ie_t       du_ie;
  instr_t    if_instr, mem_instr;
  logic      if_bubble, mem_bubble, mem_exception, dmem_ack, pipe_flush;
  exc_vec_t  du_exceptions;

  vec_t  vecs[$];
  string names[$];
  xlen_t rng_state = 32'd67335;
  int    errors = 0;
  int    passed = 0;
  int    failed = 0;
  int    cycles = 0;
  int    limit = 0;
  logic  test_ok;

  du_top du_top_i (.*);

  always #2 clk = ~clk;

  // Run limit from the table length
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout after %0d cycles, DUT stopped responding", cycles);
      $display("Errors found");
      $finish;
    end
  end

  // xorshift32
  function automatic xlen_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic add_reg(input string name, input logic wr, input dbg_addr_t waddr,
                         input xlen_t wdata, input logic rnd, input xlen_t mask,
                         input dbg_addr_t raddr, input xlen_t exp);
    vec_t v;
    v = '{wr: wr, waddr: waddr, wdata: wdata, rnd: rnd, mask: mask, clr: 1'b0,
          pc: IDLE_PC, iinstr: I_OP, ibub: 1'b1, minstr: I_OP, madr: '0, mack: 1'b0,
          mexc: 1'b0, flush: 1'b0, exc: '0, raddr: raddr, exp: exp, exp_bp: 1'b0};
    vecs.push_back(v);
    names.push_back(name);
  endtask

  task automatic add_stim(input string name, input logic wr, input dbg_addr_t waddr,
                          input xlen_t wdata, input logic clr, input xlen_t pc,
                          input instr_t iinstr, input logic ibub, input instr_t minstr,
                          input xlen_t madr, input logic mack, input logic mexc,
                          input logic flush, input exc_vec_t exc, input dbg_addr_t raddr,
                          input xlen_t exp, input logic exp_bp);
    vec_t v;
    v = '{wr: wr, waddr: waddr, wdata: wdata, rnd: 1'b0, mask: '0, clr: clr, pc: pc,
          iinstr: iinstr, ibub: ibub, minstr: minstr, madr: madr, mack: mack, mexc: mexc,
          flush: flush, exc: exc, raddr: raddr, exp: exp, exp_bp: exp_bp};
    vecs.push_back(v);
    names.push_back(name);
  endtask

  `include "du_tb_vectors.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Debug port and pipeline drivers
  ////////////////////////////////////////////////////////////////////////////

  // Strobe held until ack seen, then one idle cycle
  task automatic dbg_write(input dbg_addr_t addr, input xlen_t data);
    @(negedge clk);
    dbg_strb = 1'b1;
    dbg_we   = 1'b1;
    dbg_addr = addr;
    dbg_dati = data;
    do @(negedge clk); while (!dbg_ack);
    dbg_strb = 1'b0;
    dbg_we   = 1'b0;
    @(negedge clk);
  endtask

  task automatic dbg_read(input dbg_addr_t addr, output xlen_t data);
    @(negedge clk);
    dbg_strb = 1'b1;
    dbg_we   = 1'b0;
    dbg_addr = addr;
    do @(negedge clk); while (!dbg_ack);
    data     = dbg_dato;
    dbg_strb = 1'b0;
    @(negedge clk);
  endtask

  task automatic drive_pipe(input vec_t v);
    if_pc         = v.pc;
    if_instr      = v.iinstr;
    if_bubble     = v.ibub;
    mem_instr     = v.minstr;
    mem_memadr    = v.madr;
    dmem_ack      = v.mack;
    // Memory stage empty unless a load or store sits in it
    mem_bubble    = (v.minstr == I_OP);
    mem_exception = v.mexc;
    pipe_flush    = v.flush;
    du_exceptions = v.exc;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_ie(input string name, input ie_t exp, input ie_t act);
    if (act !== exp) begin
      $display("Fail %s du_ie expected %h actual %h", name, exp, act);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s expected %b actual %b", name, exp, act);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    vec_t  idle;
    vec_t  v;
    xlen_t r;
    xlen_t exp;
    xlen_t rd;
    rstn     = 1'b0;
    dbg_strb = 1'b0;
    dbg_we   = 1'b0;
    dbg_addr = '0;
    dbg_dati = '0;
    idle = '{pc: IDLE_PC, iinstr: I_OP, ibub: 1'b1, minstr: I_OP, default: '0};
    drive_pipe(idle);
    fill_table();
    limit = 40 * vecs.size() + 100;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    test_ok = 1'b1;
    check_bit("reset_ack", 1'b0, dbg_ack);
    check_bit("reset_bp", 1'b0, dbg_bp);
    $display("Test reset_outputs %s", test_ok ? "ok" : "failed");

    foreach (vecs[i]) begin
      v       = vecs[i];
      test_ok = 1'b1;
      r       = next_rand();
      if (v.wr) begin
        dbg_write(v.waddr, v.rnd ? r : v.wdata);
      end
      exp = v.rnd ? (r & v.mask) : v.exp;
      if (v.clr) begin
        dbg_write(`DU_REG_HIT, '0);
      end
      // One cycle of pipeline activity, break request sampled after it
      drive_pipe(v);
      @(negedge clk);
      drive_pipe(idle);
      check_bit({names[i], "_dbg_bp"}, v.exp_bp, dbg_bp);
      dbg_read(v.raddr, rd);
      check_word(names[i], exp, rd);
      if (v.rnd && v.raddr == dbg_addr_t'(`DU_REG_IE)) begin
        check_ie(names[i], ie_t'(exp), du_ie);
      end
      if (test_ok) begin
        passed++;
      end else begin
        failed++;
      end
      $display("Test %s %s", names[i], test_ok ? "ok" : "failed");
    end

    $display("Tests %0d passed %0d failed, %0d check errors", passed, failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+src
+incdir+verif
src/du_pkg.sv
src/du_access.sv
src/cause_enc.sv
src/bp_match.sv
src/du_regs.sv
src/du_top.sv
verif/du_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the debug unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module du_tb -f vlog.f -o du_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/du_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

cat sim.log
if grep -q "^No errors$" sim.log; then
  exit 0
fi
exit 1
